//--- Makefile
VERILATOR ?= verilator
TOP       := tb_cnn
FILELIST  := sources.f
VFLAGS    := --binary --timing --assert -j 0 --timescale 1ns/1ps --top-module $(TOP)
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) cnn_cfg.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- axil_param_regs.sv
`include "cnn_cfg.svh"

module axil_param_regs import cnn_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  axil_req_t   req,
	output axil_rsp_t   rsp,
	input  logic        frame_done,
	output kernel_set_t kernels
);

	localparam int AW = `CNN_AXIL_AW;
	// low address bits pick the word inside one map
	localparam int IDX_W = $clog2(`CNN_MAP_STRIDE);
	localparam int MAP_W = $clog2(`CNN_MAPS);
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic awready_q;
	logic bvalid_q;
	logic [1:0] bresp_q;
	logic rvalid_q;
	logic [1:0] rresp_q;
	logic [31:0] rdata_q;
	// completed input frames
	logic [31:0] frames_q;

	logic wr_go;
	logic wr_ok;
	logic [MAP_W-1:0] wr_map;
	logic [IDX_W-1:0] wr_idx;
	logic rd_go;
	logic rd_ok;
	logic [MAP_W-1:0] rd_map;
	logic [IDX_W-1:0] rd_idx;
	logic [31:0] rd_val;

	// true for a weight or bias word of an existing map
	function automatic logic kern_addr(input logic [AW-1:0] addr);
		return (addr[AW-1:IDX_W+MAP_W] == '0) &&
			(addr[IDX_W-1:0] <= IDX_W'(`CNN_BIAS_IDX));
	endfunction

	// take address and data together once no write response is pending
	assign wr_go = req.awvalid && req.wvalid && !bvalid_q && !awready_q;
	assign wr_ok = kern_addr(req.awaddr);
	assign wr_map = req.awaddr[IDX_W +: MAP_W];
	assign wr_idx = req.awaddr[IDX_W-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			awready_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			// ready lasts a single cycle
			awready_q <= wr_go;
			if (awready_q) begin
				bvalid_q <= 1'b1;
			end else if (req.bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	// counter word and unmapped words answer slverr
	always_ff @(posedge clk) begin
		if (awready_q) begin
			bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// weights and biases change on the accepting cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			kernels <= '0;
		end else if (awready_q && wr_ok && |req.wstrb) begin
			if (wr_idx == IDX_W'(`CNN_BIAS_IDX)) begin
				kernels[wr_map].bias <= req.wdata[`CNN_FEAT_W-1:0];
			end else begin
				kernels[wr_map].w[wr_idx] <= req.wdata[`CNN_COEF_W-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			frames_q <= '0;
		end else if (frame_done) begin
			frames_q <= frames_q + 32'd1;
		end
	end

	// read side takes a new address only while no data is held
	assign rd_go = req.arvalid && !rvalid_q;
	assign rd_map = req.araddr[IDX_W +: MAP_W];
	assign rd_idx = req.araddr[IDX_W-1:0];

	// read mux with sign extension to the bus width
	always_comb begin
		rd_ok = 1'b1;
		rd_val = '0;
		if (req.araddr == `CNN_FRAMES_ADDR) begin
			rd_val = frames_q;
		end else if (!kern_addr(req.araddr)) begin
			rd_ok = 1'b0;
		end else if (rd_idx == IDX_W'(`CNN_BIAS_IDX)) begin
			rd_val = 32'($signed(kernels[rd_map].bias));
		end else begin
			rd_val = 32'($signed(kernels[rd_map].w[rd_idx]));
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rvalid_q <= 1'b0;
		end else if (rd_go) begin
			rvalid_q <= 1'b1;
		end else if (req.rready) begin
			rvalid_q <= 1'b0;
		end
	end

	// data stays put until the master takes it
	always_ff @(posedge clk) begin
		if (rd_go) begin
			rdata_q <= rd_val;
			rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	always_comb begin
		rsp.awready = awready_q;
		rsp.wready = awready_q;
		rsp.bresp = bresp_q;
		rsp.bvalid = bvalid_q;
		rsp.arready = !rvalid_q;
		rsp.rdata = rdata_q;
		rsp.rresp = rresp_q;
		rsp.rvalid = rvalid_q;
	end

endmodule

//--- cnn_cfg.svh
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// input frame size in pixels
`define CNN_IMG_COLS 12
`define CNN_IMG_ROWS 12

// square kernel side
`define CNN_K 3

// feature maps computed side by side
`define CNN_MAPS 2

// word sizes
`define CNN_PIX_W 8
`define CNN_COEF_W 8
`define CNN_FEAT_W 16
// nine 8x8 products plus a 16 bit bias fit without overflow
`define CNN_ACC_W 20

// register map in word addresses
`define CNN_AXIL_AW 8
`define CNN_MAP_STRIDE 16
`define CNN_BIAS_IDX 9
`define CNN_FRAMES_ADDR 8'h80

`endif

//--- cnn_chk.sv
module cnn_chk import cnn_pkg::*; (
	input logic       clk,
	input logic       arst_n,
	input axil_req_t  axil_req,
	input axil_rsp_t  axil_rsp,
	input feat_beat_t feat_out
);

	timeunit 1ns;
	timeprecision 1ps;

	// write response waits for the master
	ap_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
		else $error("bvalid dropped before bready");

	// read data held steady until taken
	ap_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
		else $error("rvalid or rdata changed before rready");

	// pooling fires on odd columns only
	ap_feat_spacing: assert property (@(posedge clk) disable iff (!arst_n)
		feat_out.valid |=> !feat_out.valid)
		else $error("pooled beats on two consecutive cycles");

	ap_aw_ready: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.awready |-> axil_req.awvalid && axil_req.wvalid)
		else $error("awready without awvalid and wvalid");

endmodule

bind cnn_top cnn_chk u_chk (
	.clk      (clk),
	.arst_n   (arst_n),
	.axil_req (axil_req),
	.axil_rsp (axil_rsp),
	.feat_out (feat_out)
);

//--- cnn_pkg.sv
`include "cnn_cfg.svh"

package cnn_pkg;

	typedef logic signed [`CNN_PIX_W-1:0] pix_t;
	typedef logic signed [`CNN_COEF_W-1:0] coef_t;
	typedef logic signed [`CNN_FEAT_W-1:0] feat_t;

	// one pixel of the raster stream
	typedef struct packed {
		logic valid;
		pix_t pix;
	} pix_beat_t;

	// row-major taps with the oldest row and leftmost column at index 0
	typedef struct packed {
		logic valid;
		pix_t [0:`CNN_K*`CNN_K-1] pix;
	} window_t;

	// tap order matches window_t and the register word index
	typedef struct packed {
		coef_t [0:`CNN_K*`CNN_K-1] w;
		feat_t bias;
	} kernel_t;

	typedef kernel_t [0:`CNN_MAPS-1] kernel_set_t;
	typedef feat_t [0:`CNN_MAPS-1] feat_vec_t;

	// valid-qualified result beat for all maps
	typedef struct packed {
		logic valid;
		logic last;
		feat_vec_t feat;
	} feat_beat_t;

	// axi4-lite master to slave
	typedef struct packed {
		logic [`CNN_AXIL_AW-1:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		logic [`CNN_AXIL_AW-1:0] araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	// axi4-lite slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [31:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axil_rsp_t;

endpackage

//--- cnn_top.sv
`include "cnn_cfg.svh"

module cnn_top import cnn_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  axil_req_t  axil_req,
	output axil_rsp_t  axil_rsp,
	input  pix_beat_t  pix_in,
	output feat_beat_t feat_out
);

	// weights and biases from the register block
	kernel_set_t kernels;
	// window of the pixel being accepted
	window_t window;
	// last pixel of a frame seen
	logic frame_done;
	// conv and relu result ahead of pooling
	feat_beat_t conv_beat;

	axil_param_regs u_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.req        (axil_req),
		.rsp        (axil_rsp),
		.frame_done (frame_done),
		.kernels    (kernels)
	);

	line_window u_window (
		.clk        (clk),
		.arst_n     (arst_n),
		.pix_in     (pix_in),
		.window     (window),
		.frame_done (frame_done)
	);

	// c1 layer
	conv_relu u_conv (
		.clk      (clk),
		.arst_n   (arst_n),
		.window   (window),
		.kernels  (kernels),
		.conv_out (conv_beat)
	);

	// s2 layer
	max_pool u_pool (
		.clk      (clk),
		.arst_n   (arst_n),
		.conv_in  (conv_beat),
		.pool_out (feat_out)
	);

endmodule

//--- conv_relu.sv
`include "cnn_cfg.svh"

module conv_relu import cnn_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  window_t     window,
	input  kernel_set_t kernels,
	output feat_beat_t  conv_out
);

	localparam int ACC_W = `CNN_ACC_W;
	localparam int TAPS = `CNN_K * `CNN_K;
	// signed 16 bit limits held at accumulator width
	localparam logic signed [ACC_W-1:0] FEAT_MAX = ACC_W'(2 ** (`CNN_FEAT_W - 1) - 1);
	localparam logic signed [ACC_W-1:0] FEAT_MIN = ACC_W'(-(2 ** (`CNN_FEAT_W - 1)));

	logic valid_q;
	feat_vec_t feat_q;
	feat_vec_t feat_d;

	// one map: multiply-accumulate, bias, saturate, relu
	function automatic feat_t map_value(input window_t win, input kernel_t kern);
		logic signed [ACC_W-1:0] acc;
		logic signed [ACC_W-1:0] sat;
		acc = '0;
		for (int k = 0; k < TAPS; k++) begin
			acc += ACC_W'($signed(win.pix[k])) * ACC_W'($signed(kern.w[k]));
		end
		acc += ACC_W'($signed(kern.bias));
		if (acc > FEAT_MAX) begin
			sat = FEAT_MAX;
		end else if (acc < FEAT_MIN) begin
			sat = FEAT_MIN;
		end else begin
			sat = acc;
		end
		// relu drops anything below zero
		if (sat < 0) begin
			sat = '0;
		end
		return feat_t'(sat[`CNN_FEAT_W-1:0]);
	endfunction

	// all maps in parallel on the same window
	always_comb begin
		for (int m = 0; m < `CNN_MAPS; m++) begin
			feat_d[m] = map_value(window, kernels[m]);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= window.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (window.valid) begin
			feat_q <= feat_d;
		end
	end

	// last is not known at this stage
	always_comb begin
		conv_out.valid = valid_q;
		conv_out.last = 1'b0;
		conv_out.feat = feat_q;
	end

endmodule

//--- line_window.sv
`include "cnn_cfg.svh"

module line_window import cnn_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  pix_beat_t pix_in,
	output window_t   window,
	output logic      frame_done
);

	localparam int K = `CNN_K;
	localparam int COLS = `CNN_IMG_COLS;
	localparam int CW = $clog2(`CNN_IMG_COLS);
	localparam int RW = $clog2(`CNN_IMG_ROWS);

	// position of the pixel on the input right now
	logic [CW-1:0] col_q;
	logic [RW-1:0] row_q;
	logic last_col;
	logic last_row;

	// one line buffer per earlier window row, index 0 is the oldest row
	pix_t line_q [K-1][COLS];
	// window columns left of the incoming pixel, index 0 is leftmost
	pix_t [0:K-1] hist_q [K-1];
	// column completed by this pixel, oldest row first
	pix_t [0:K-1] cur;

	assign last_col = (col_q == CW'(COLS - 1));
	assign last_row = (row_q == RW'(`CNN_IMG_ROWS - 1));

	// pulse with the final pixel of each frame
	assign frame_done = pix_in.valid && last_col && last_row;

	// raster counters wrap at the frame end
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			col_q <= '0;
			row_q <= '0;
		end else if (pix_in.valid) begin
			if (last_col) begin
				col_q <= '0;
				row_q <= last_row ? '0 : row_q + 1'b1;
			end else begin
				col_q <= col_q + 1'b1;
			end
		end
	end

	// stored rows above plus the live pixel at the bottom
	always_comb begin
		for (int r = 0; r < K - 1; r++) begin
			cur[r] = line_q[r][col_q];
		end
		cur[K-1] = pix_in.pix;
	end

	// each buffer moves up one row and the window shifts left
	always_ff @(posedge clk) begin
		if (pix_in.valid) begin
			for (int r = 0; r < K - 1; r++) begin
				line_q[r][col_q] <= cur[r+1];
			end
			for (int c = 0; c < K - 2; c++) begin
				hist_q[c] <= hist_q[c+1];
			end
			hist_q[K-2] <= cur;
		end
	end

	// window is only meaningful once a full kernel fits above and left
	always_comb begin
		window.valid = pix_in.valid && (row_q >= RW'(K - 1)) && (col_q >= CW'(K - 1));
		for (int r = 0; r < K; r++) begin
			for (int c = 0; c < K - 1; c++) begin
				window.pix[r*K+c] = hist_q[c][r];
			end
			// rightmost tap comes straight from this column
			window.pix[r*K+K-1] = cur[r];
		end
	end

endmodule

//--- max_pool.sv
`include "cnn_cfg.svh"

module max_pool import cnn_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  feat_beat_t conv_in,
	output feat_beat_t pool_out
);

	// conv map size after a valid-only convolution
	localparam int CONV_COLS = `CNN_IMG_COLS - `CNN_K + 1;
	localparam int CONV_ROWS = `CNN_IMG_ROWS - `CNN_K + 1;
	localparam int CW = $clog2(CONV_COLS);
	localparam int RW = $clog2(CONV_ROWS);

	logic [CW-1:0] col_q;
	logic [RW-1:0] row_q;
	logic last_col;
	logic last_row;
	// second row and second column of a 2x2 block
	logic fire;

	// even conv row kept for the row below it
	feat_vec_t row_buf [CONV_COLS];
	// previous result on the current row
	feat_vec_t left_q;
	feat_vec_t max_d;
	logic valid_q;
	logic last_q;
	feat_vec_t feat_q;

	function automatic feat_t max2(input feat_t a, input feat_t b);
		return (a > b) ? a : b;
	endfunction

	assign last_col = (col_q == CW'(CONV_COLS - 1));
	assign last_row = (row_q == RW'(CONV_ROWS - 1));
	assign fire = conv_in.valid && row_q[0] && col_q[0];

	// own position count of conv results
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			col_q <= '0;
			row_q <= '0;
		end else if (conv_in.valid) begin
			if (last_col) begin
				col_q <= '0;
				row_q <= last_row ? '0 : row_q + 1'b1;
			end else begin
				col_q <= col_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (conv_in.valid) begin
			left_q <= conv_in.feat;
			if (!row_q[0]) begin
				row_buf[col_q] <= conv_in.feat;
			end
		end
	end

	// four-way maximum per map over the 2x2 block
	always_comb begin
		for (int m = 0; m < `CNN_MAPS; m++) begin
			max_d[m] = max2(max2(conv_in.feat[m], left_q[m]),
				max2(row_buf[col_q-1'b1][m], row_buf[col_q][m]));
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
			last_q <= 1'b0;
		end else begin
			valid_q <= fire;
			// bottom-right block closes the frame
			last_q <= fire && last_row && last_col;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			feat_q <= max_d;
		end
	end

	always_comb begin
		pool_out.valid = valid_q;
		pool_out.last = last_q;
		pool_out.feat = feat_q;
	end

endmodule

//--- sources.f
+incdir+.
cnn_pkg.sv
axil_param_regs.sv
line_window.sv
conv_relu.sv
max_pool.sv
cnn_top.sv
cnn_chk.sv
tb_cnn.sv

//--- tb_cnn.sv
`include "cnn_cfg.svh"

module tb_cnn import cnn_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int AW = `CNN_AXIL_AW;
	localparam int ROWS = `CNN_IMG_ROWS;
	localparam int COLS = `CNN_IMG_COLS;
	localparam int TAPS = `CNN_K * `CNN_K;
	// pooled grid side, half of the valid conv map
	localparam int POOL = (`CNN_IMG_COLS - `CNN_K + 1) / 2;
	localparam int FRAMES_ADDR = int'(`CNN_FRAMES_ADDR);
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;
	// about 130 bus transactions of at most 8 cycles each
	localparam int TXN_CYCLES = 130 * 8;
	// one frame without gaps, two with up to two idle cycles per pixel
	localparam int PIX_CYCLES = ROWS * COLS + 2 * 3 * ROWS * COLS;
	localparam int MAX_CYCLES = TXN_CYCLES + PIX_CYCLES + 300;

	logic clk;
	logic arst_n;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	pix_beat_t pix_in;
	feat_beat_t feat_out;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	// complete frames streamed into the DUT so far
	int frames_sent = 0;

	// model copies of the programmed kernels and of the frame being sent
	int w_ref [`CNN_MAPS][TAPS];
	int b_ref [`CNN_MAPS];
	int img [ROWS][COLS];
	feat_beat_t exp_q [$];
	feat_beat_t got_q [$];

	cnn_top UUT (
		.clk      (clk),
		.arst_n   (arst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.pix_in   (pix_in),
		.feat_out (feat_out)
	);

	always #10 clk = ~clk;

	// pooled beats are registered, settled by the falling edge
	always @(negedge clk) begin
		if (feat_out.valid) begin
			got_q.push_back(feat_out);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input int got, input int exp);
		errors++;
		$display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("error at %0t: %s", $time, what);
	endtask

	function automatic int word_addr(input int m, input int k);
		return m * `CNN_MAP_STRIDE + k;
	endfunction

	// address and data together, hold until the edge where ready is seen
	task automatic axil_write(input int addr, input int data, input logic [3:0] strb,
		output logic [1:0] resp);
		axil_req.awaddr = AW'(addr);
		axil_req.wdata = 32'(data);
		axil_req.wstrb = strb;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid = 1'b1;
		axil_req.bready = 1'b1;
		@(posedge clk);
		#2;
		while (!axil_rsp.awready) begin
			@(posedge clk);
			#2;
		end
		// both ready lines rise in the same cycle
		checks++;
		if (axil_rsp.wready !== 1'b1) begin
			report_mismatch("axil_rsp.wready", int'(axil_rsp.wready), 1);
		end
		// handshake happens on this edge
		@(posedge clk);
		#2;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		while (!axil_rsp.bvalid) begin
			@(posedge clk);
			#2;
		end
		resp = axil_rsp.bresp;
		@(posedge clk);
		#2;
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input int addr, output logic [31:0] data, output logic [1:0] resp);
		axil_req.araddr = AW'(addr);
		axil_req.arvalid = 1'b1;
		axil_req.rready = 1'b1;
		while (!axil_rsp.arready) begin
			@(posedge clk);
			#2;
		end
		@(posedge clk);
		#2;
		axil_req.arvalid = 1'b0;
		while (!axil_rsp.rvalid) begin
			@(posedge clk);
			#2;
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge clk);
		#2;
		axil_req.rready = 1'b0;
	endtask

	task automatic check_read(input int addr, input int exp, input logic [1:0] exp_resp);
		logic [31:0] data;
		logic [1:0] resp;
		axil_read(addr, data, resp);
		checks++;
		if (resp !== exp_resp) begin
			report_mismatch($sformatf("axil_rsp.rresp @0x%02h", addr), int'(resp), int'(exp_resp));
		end
		if (data !== 32'(exp)) begin
			report_mismatch($sformatf("axil_rsp.rdata @0x%02h", addr), int'(data), exp);
		end
	endtask

	task automatic write_word(input int addr, input int data);
		logic [1:0] resp;
		axil_write(addr, data, 4'hf, resp);
		checks++;
		if (resp !== OKAY) begin
			report_mismatch("axil_rsp.bresp", int'(resp), int'(OKAY));
		end
	endtask

	// push the model kernels into the register block
	task automatic load_kernels();
		for (int m = 0; m < `CNN_MAPS; m++) begin
			for (int k = 0; k < TAPS; k++) begin
				write_word(word_addr(m, k), w_ref[m][k]);
			end
			write_word(word_addr(m, `CNN_BIAS_IDX), b_ref[m]);
		end
	endtask

	// one conv output with bias, 16 bit saturation and relu
	function automatic int conv_ref(input int m, input int r, input int c);
		int acc;
		acc = b_ref[m];
		for (int k = 0; k < TAPS; k++) begin
			acc += img[r + k / `CNN_K][c + k % `CNN_K] * w_ref[m][k];
		end
		if (acc > 32767) begin
			acc = 32767;
		end else if (acc < -32768) begin
			acc = -32768;
		end
		if (acc < 0) begin
			acc = 0;
		end
		return acc;
	endfunction

	// expected pooled beats of the current frame in raster order
	task automatic push_expected();
		feat_beat_t beat;
		int v;
		for (int i = 0; i < POOL; i++) begin
			for (int j = 0; j < POOL; j++) begin
				beat.valid = 1'b1;
				beat.last = (i == POOL - 1) && (j == POOL - 1);
				for (int m = 0; m < `CNN_MAPS; m++) begin
					// relu output is never negative
					v = 0;
					for (int d = 0; d < 4; d++) begin
						if (conv_ref(m, 2 * i + d / 2, 2 * j + d % 2) > v) begin
							v = conv_ref(m, 2 * i + d / 2, 2 * j + d % 2);
						end
					end
					beat.feat[m] = 16'(v);
				end
				exp_q.push_back(beat);
			end
		end
	endtask

	task automatic fill_frame(input int lo, input int span);
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				img[r][c] = lo + int'($urandom % span);
			end
		end
	endtask

	task automatic stream_frame(input bit gaps);
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				if (gaps) begin
					pix_in.valid = 1'b0;
					repeat ($urandom % 3) begin
						@(posedge clk);
						#2;
					end
				end
				pix_in.valid = 1'b1;
				pix_in.pix = pix_t'(img[r][c]);
				@(posedge clk);
				#2;
			end
		end
		pix_in.valid = 1'b0;
		frames_sent++;
	endtask

	// wait for the pipeline to drain, then compare beat by beat
	task automatic compare_beats();
		int waited;
		feat_beat_t got;
		feat_beat_t exp;
		waited = 0;
		while (got_q.size() < exp_q.size() && waited < 40) begin
			@(posedge clk);
			#2;
			waited++;
		end
		checks++;
		if (got_q.size() != exp_q.size()) begin
			report_failure($sformatf("%0d pooled beats seen but %0d expected",
				got_q.size(), exp_q.size()));
		end
		while (got_q.size() > 0 && exp_q.size() > 0) begin
			got = got_q.pop_front();
			exp = exp_q.pop_front();
			for (int m = 0; m < `CNN_MAPS; m++) begin
				if (got.feat[m] !== exp.feat[m]) begin
					report_mismatch($sformatf("feat_out.feat[%0d]", m),
						int'(got.feat[m]), int'(exp.feat[m]));
				end
			end
			if (got.last !== exp.last) begin
				report_mismatch("feat_out.last", int'(got.last), int'(exp.last));
			end
		end
		got_q.delete();
		exp_q.delete();
	endtask

	task automatic test_reset_state();
		checks++;
		if (feat_out.valid !== 1'b0) begin
			report_mismatch("feat_out.valid", int'(feat_out.valid), 0);
		end
		for (int m = 0; m < `CNN_MAPS; m++) begin
			for (int k = 0; k <= `CNN_BIAS_IDX; k++) begin
				check_read(word_addr(m, k), 0, OKAY);
			end
		end
		check_read(FRAMES_ADDR, 0, OKAY);
	endtask

	task automatic test_readback();
		logic [1:0] resp;
		for (int m = 0; m < `CNN_MAPS; m++) begin
			for (int k = 0; k < TAPS; k++) begin
				w_ref[m][k] = int'($signed(8'($urandom)));
			end
			b_ref[m] = int'($signed(16'($urandom)));
		end
		load_kernels();
		for (int m = 0; m < `CNN_MAPS; m++) begin
			for (int k = 0; k < TAPS; k++) begin
				check_read(word_addr(m, k), w_ref[m][k], OKAY);
			end
			check_read(word_addr(m, `CNN_BIAS_IDX), b_ref[m], OKAY);
		end
		// no byte lanes enabled, old weight stays
		axil_write(word_addr(0, 1), ~w_ref[0][1], 4'h0, resp);
		check_read(word_addr(0, 1), w_ref[0][1], OKAY);
	endtask

	task automatic test_error_resp();
		logic [1:0] resp;
		check_read(32'h0c, 0, SLVERR);
		axil_write(FRAMES_ADDR, 32'h1234, 4'hf, resp);
		checks++;
		if (resp !== SLVERR) begin
			report_mismatch("axil_rsp.bresp", int'(resp), int'(SLVERR));
		end
		check_read(FRAMES_ADDR, 0, OKAY);
	endtask

	task automatic test_identity();
		for (int m = 0; m < `CNN_MAPS; m++) begin
			for (int k = 0; k < TAPS; k++) begin
				w_ref[m][k] = 0;
			end
		end
		w_ref[0][TAPS / 2] = 1;
		w_ref[1][TAPS / 2] = -1;
		b_ref[0] = 0;
		b_ref[1] = 5;
		load_kernels();
		fill_frame(-128, 256);
		push_expected();
		stream_frame(1'b0);
		compare_beats();
	endtask

	task automatic test_saturation();
		// map 0 strongly positive, map 1 strongly negative
		for (int k = 0; k < TAPS; k++) begin
			w_ref[0][k] = 100 + int'($urandom % 28);
			w_ref[1][k] = -100 - int'($urandom % 29);
		end
		for (int m = 0; m < `CNN_MAPS; m++) begin
			b_ref[m] = int'($urandom % 4096) - 2048;
		end
		load_kernels();
		check_read(FRAMES_ADDR, frames_sent, OKAY);
		// bright frame pins map 0 at the top and map 1 at zero
		fill_frame(64, 64);
		push_expected();
		stream_frame(1'b1);
		fill_frame(-128, 256);
		push_expected();
		stream_frame(1'b1);
		compare_beats();
		check_read(FRAMES_ADDR, frames_sent, OKAY);
	endtask

	initial begin
		void'($urandom(32'h3d540e24));
		clk = 1'b0;
		arst_n = 1'b0;
		axil_req = '0;
		pix_in = '0;
		repeat (2) @(posedge clk);
		#2;
		arst_n = 1'b1;
		test_reset_state();
		test_readback();
		test_error_resp();
		test_identity();
		test_saturation();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
